// File: logic/eth_tx_macros.svh
`ifndef ETH_TX_MACROS_SVH
`define ETH_TX_MACROS_SVH

// Payload carried in every UDP datagram
`define ETH_DATA_BYTES 16

// Header and trailer sizes in bytes
`define ETH_MAC_HDR_BYTES 14
`define ETH_IP_HDR_BYTES 20
`define ETH_UDP_HDR_BYTES 8
`define ETH_FCS_BYTES 4

// UDP length covers its own header plus payload
`define ETH_UDP_BYTES (`ETH_UDP_HDR_BYTES + `ETH_DATA_BYTES)
// IP total length covers IP header plus UDP datagram
`define ETH_IP_BYTES (`ETH_IP_HDR_BYTES + `ETH_UDP_BYTES)

// Zero bytes after the payload up to a multiple of 4
`define ETH_PAD_BYTES ((4 - ((`ETH_MAC_HDR_BYTES + `ETH_IP_BYTES) % 4)) % 4)

// Destination MAC through end of padding
`define ETH_FRAME_BYTES (`ETH_MAC_HDR_BYTES + `ETH_IP_BYTES + `ETH_PAD_BYTES)
`define ETH_BODY_NIBBLES (2 * `ETH_FRAME_BYTES)
`define ETH_FCS_NIBBLES (2 * `ETH_FCS_BYTES)

// Line overhead around the body
`define ETH_PREAMBLE_NIBBLES 16
`define ETH_GAP_NIBBLES 24

// Fixed header values
`define ETH_TYPE_IPV4 16'h0800
`define ETH_IP_TTL 8'd255
`define ETH_IP_PROTO_UDP 8'd17

`endif

// File: logic/eth_tx_pkg.sv
`include "eth_tx_macros.svh"

package eth_tx_pkg;

    // Ethernet MAC header, destination goes out first
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] ether_type;
    } mac_header_t;

    // RFC 791 header without options
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  tos;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] frag_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] checksum;
        logic [31:0] src_ip;
        logic [31:0] dest_ip;
    } ip_fields_t;

    // Same bits as the words the header checksum runs over
    typedef union packed {
        ip_fields_t                               fields;
        logic [`ETH_IP_HDR_BYTES/2-1:0][15:0]     words;
    } ip_header_u;

    // RFC 768 header
    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_header_t;

    // Frame without FCS, first byte at the MSB end
    typedef struct packed {
        mac_header_t mac;
        ip_header_u  ip;
        udp_header_t udp;
        logic [8*(`ETH_DATA_BYTES+`ETH_PAD_BYTES)-1:0] data;
    } eth_frame_t;

    // Running CRC-32, reflected bit order
    typedef logic [31:0] crc32_t;

endpackage

// File: logic/nibble_if.sv
interface nibble_if;

    // Nibble on the line this cycle
    logic [3:0] nibble;
    // Nibble valid
    logic en;
    // Frame nibble as opposed to preamble/SFD
    logic body;
    // Final frame nibble, FCS comes next
    logic last;

    modport src (
        output nibble,
        output en,
        output body,
        output last
    );

    modport dst (
        input nibble,
        input en,
        input body,
        input last
    );

endinterface

// File: logic/frame_builder.sv
`include "eth_tx_macros.svh"

module frame_builder import eth_tx_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         send,
    input  logic                         tx_done,
    input  logic [8*`ETH_DATA_BYTES-1:0] payload,
    input  logic [47:0]                  src_mac,
    input  logic [47:0]                  dest_mac,
    input  logic [31:0]                  src_ip,
    input  logic [31:0]                  dest_ip,
    input  logic [15:0]                  src_port,
    input  logic [15:0]                  dest_port,
    output logic                         ready,
    output logic                         frame_valid,
    output eth_frame_t                   frame
);

    // Last sampled send
    logic send_prev;
    // Frame register loaded so valid goes out next
    logic launch;
    logic accept;

    // Fresh rising edge while idle
    assign accept = send && !send_prev && ready && !launch;

    always_ff @(posedge clk) begin
        if (reset) begin
            // Follows send through reset so a level held high is no edge
            send_prev   <= send;
            launch      <= 1'b0;
            frame_valid <= 1'b0;
            ready       <= 1'b1;
        end else begin
            send_prev   <= send;
            launch      <= accept;
            frame_valid <= launch;
            if (launch) begin
                ready <= 1'b0;
            end else if (tx_done) begin
                ready <= 1'b1;
            end
        end
    end

    // Headers and payload captured on the accepted edge
    always_ff @(posedge clk) begin
        if (accept) begin
            frame.mac.dest_mac            <= dest_mac;
            frame.mac.src_mac             <= src_mac;
            frame.mac.ether_type          <= `ETH_TYPE_IPV4;
            frame.ip.fields.version       <= 4'd4;
            frame.ip.fields.ihl           <= 4'(`ETH_IP_HDR_BYTES / 4);
            frame.ip.fields.tos           <= '0;
            frame.ip.fields.total_length  <= 16'(`ETH_IP_BYTES);
            frame.ip.fields.identification <= '0;
            frame.ip.fields.flags         <= '0;
            frame.ip.fields.frag_offset   <= '0;
            frame.ip.fields.ttl           <= `ETH_IP_TTL;
            frame.ip.fields.protocol      <= `ETH_IP_PROTO_UDP;
            // Filled in by the checksum stage
            frame.ip.fields.checksum      <= '0;
            frame.ip.fields.src_ip        <= src_ip;
            frame.ip.fields.dest_ip       <= dest_ip;
            frame.udp.src_port            <= src_port;
            frame.udp.dest_port           <= dest_port;
            frame.udp.length              <= 16'(`ETH_UDP_BYTES);
            // UDP checksum unused since zero is legal over IPv4
            frame.udp.checksum            <= '0;
            // Payload on top with zero padding below
            frame.data <= '0;
            frame.data[$bits(frame.data)-1 -: 8*`ETH_DATA_BYTES] <= payload;
        end
    end

    // Serializer must only finish a frame this stage launched
    assert property (@(posedge clk) disable iff (reset) tx_done |-> !ready)
        else $error("tx_done while ready is high");

endmodule

// File: logic/ip_checksum_stage.sv
`include "eth_tx_macros.svh"

module ip_checksum_stage import eth_tx_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       frame_valid,
    input  eth_frame_t frame,
    output logic       sum_valid,
    output eth_frame_t sum_frame
);

    // Sum registered, checksum field not yet written
    logic        pending;
    logic [31:0] word_sum;
    logic [31:0] sum_comb;
    logic [16:0] fold_1;
    logic [15:0] fold_2;

    // Checksum field is still zero here so all ten words can be summed
    always_comb begin
        sum_comb = '0;
        for (int w = 0; w < `ETH_IP_HDR_BYTES / 2; w++) begin
            sum_comb = sum_comb + 32'(frame.ip.words[w]);
        end
    end

    // End-around carry folded twice
    assign fold_1 = 17'(word_sum[31:16]) + 17'(word_sum[15:0]);
    assign fold_2 = fold_1[15:0] + 16'(fold_1[16]);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending   <= 1'b0;
            sum_valid <= 1'b0;
        end else begin
            pending   <= frame_valid;
            sum_valid <= pending;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_valid) begin
            word_sum  <= sum_comb;
            sum_frame <= frame;
        end else if (pending) begin
            // One's complement of the folded sum
            sum_frame.ip.fields.checksum <= ~fold_2;
        end
    end

    // Builder holds off until the serializer is done
    assert property (@(posedge clk) disable iff (reset) frame_valid |-> !pending)
        else $error("frame_valid while a checksum is pending");

endmodule

// File: logic/mii_serializer.sv
`include "eth_tx_macros.svh"

module mii_serializer import eth_tx_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       sum_valid,
    input  eth_frame_t sum_frame,
    output logic       tx_done,
    nibble_if.src      nib
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_BODY,
        ST_GAP
    } state_t;

    state_t state;
    // Cycles left in the current state minus one
    logic [6:0] cnt;
    // Frame bytes shifted up one byte per nibble pair
    logic [$bits(eth_frame_t)-1:0] frame_sr;
    logic [7:0] top_byte;

    assign top_byte = frame_sr[$bits(eth_frame_t)-1 -: 8];

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            cnt     <= '0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (sum_valid) begin
                        state <= ST_PREAMBLE;
                        cnt   <= 7'(`ETH_PREAMBLE_NIBBLES - 1);
                    end
                end
                ST_PREAMBLE: begin
                    if (cnt == '0) begin
                        state <= ST_BODY;
                        cnt   <= 7'(`ETH_BODY_NIBBLES - 1);
                    end else begin
                        cnt <= cnt - 7'd1;
                    end
                end
                ST_BODY: begin
                    if (cnt == '0) begin
                        // FCS slot then interframe gap
                        state <= ST_GAP;
                        cnt   <= 7'(`ETH_FCS_NIBBLES + `ETH_GAP_NIBBLES - 1);
                    end else begin
                        cnt <= cnt - 7'd1;
                    end
                end
                ST_GAP: begin
                    if (cnt == '0) begin
                        state   <= ST_IDLE;
                        tx_done <= 1'b1;
                    end else begin
                        cnt <= cnt - 7'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Odd count sends the low nibble and even count the high one before the shift
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && sum_valid) begin
            frame_sr <= sum_frame;
        end else if (state == ST_BODY && !cnt[0]) begin
            frame_sr <= frame_sr << 8;
        end
    end

    assign nib.en   = (state == ST_PREAMBLE) || (state == ST_BODY);
    assign nib.body = (state == ST_BODY);
    assign nib.last = (state == ST_BODY) && (cnt == '0);

    always_comb begin
        case (state)
            // 0x5 pattern with the SFD on the final preamble nibble
            ST_PREAMBLE: nib.nibble = (cnt == '0) ? 4'hD : 4'h5;
            ST_BODY:     nib.nibble = cnt[0] ? top_byte[3:0] : top_byte[7:4];
            default:     nib.nibble = 4'h0;
        endcase
    end

    // A new frame is only taken from idle
    assert property (@(posedge clk) disable iff (reset) sum_valid |-> state == ST_IDLE)
        else $error("sum_valid while the serializer is busy");

endmodule

// File: logic/fcs_inserter.sv
`include "eth_tx_macros.svh"

module fcs_inserter import eth_tx_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    nibble_if.dst      nib,
    output logic       tx_en,
    output logic [3:0] tx_d
);

    // Reflected 0x04C11DB7
    localparam crc32_t CRC_POLY = 32'hEDB8_8320;

    crc32_t     crc;
    // FCS nibbles going out after the body
    logic       fcs_active;
    logic [2:0] fcs_cnt;

    // Four CRC steps over the nibble LSB first
    function automatic crc32_t crc_step(input crc32_t c, input logic [3:0] d);
        crc32_t r;
        r = c;
        for (int b = 0; b < 4; b++) begin
            if (r[0] ^ d[b]) begin
                r = (r >> 1) ^ CRC_POLY;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_en      <= 1'b0;
            tx_d       <= 4'h0;
            fcs_active <= 1'b0;
            fcs_cnt    <= '0;
        end else if (nib.en) begin
            tx_en <= 1'b1;
            tx_d  <= nib.nibble;
            if (nib.last) begin
                fcs_active <= 1'b1;
                fcs_cnt    <= 3'(`ETH_FCS_NIBBLES - 1);
            end
        end else if (fcs_active) begin
            // Complemented CRC goes out least significant nibble first
            tx_en <= 1'b1;
            tx_d  <= ~crc[3:0];
            if (fcs_cnt == '0) begin
                fcs_active <= 1'b0;
            end else begin
                fcs_cnt <= fcs_cnt - 3'd1;
            end
        end else begin
            tx_en <= 1'b0;
            tx_d  <= 4'h0;
        end
    end

    always_ff @(posedge clk) begin
        if (nib.en && !nib.body) begin
            // Preset during preamble
            crc <= '1;
        end else if (nib.body) begin
            crc <= crc_step(crc, nib.nibble);
        end else if (fcs_active) begin
            crc <= crc >> 4;
        end
    end

    // Serializer gap keeps the next preamble clear of the FCS slot
    assert property (@(posedge clk) disable iff (reset) fcs_active |-> !nib.en)
        else $error("nibble input while the FCS is going out");

endmodule

// File: logic/eth_udp_tx.sv
`include "eth_tx_macros.svh"

module eth_udp_tx import eth_tx_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         send,
    input  logic [8*`ETH_DATA_BYTES-1:0] payload,
    input  logic [47:0]                  src_mac,
    input  logic [47:0]                  dest_mac,
    input  logic [31:0]                  src_ip,
    input  logic [31:0]                  dest_ip,
    input  logic [15:0]                  src_port,
    input  logic [15:0]                  dest_port,
    output logic                         ready,
    output logic                         tx_en,
    output logic [3:0]                   tx_d
);

    logic       frame_valid;
    logic       sum_valid;
    logic       tx_done;
    eth_frame_t frame;
    eth_frame_t sum_frame;

    // Serializer to FCS inserter
    nibble_if nib ();

    frame_builder i_builder (
        .clk         (clk),
        .reset       (reset),
        .send        (send),
        .tx_done     (tx_done),
        .payload     (payload),
        .src_mac     (src_mac),
        .dest_mac    (dest_mac),
        .src_ip      (src_ip),
        .dest_ip     (dest_ip),
        .src_port    (src_port),
        .dest_port   (dest_port),
        .ready       (ready),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

    ip_checksum_stage i_checksum (
        .clk         (clk),
        .reset       (reset),
        .frame_valid (frame_valid),
        .frame       (frame),
        .sum_valid   (sum_valid),
        .sum_frame   (sum_frame)
    );

    mii_serializer i_serializer (
        .clk       (clk),
        .reset     (reset),
        .sum_valid (sum_valid),
        .sum_frame (sum_frame),
        .tx_done   (tx_done),
        .nib       (nib)
    );

    fcs_inserter i_fcs (
        .clk   (clk),
        .reset (reset),
        .nib   (nib),
        .tx_en (tx_en),
        .tx_d  (tx_d)
    );

endmodule

// File: dv/eth_tx_ref.svh
`ifndef ETH_TX_REF_SVH
`define ETH_TX_REF_SVH

// Bytes on the line after the SFD, frame then FCS
`define ETH_LINE_BYTES (`ETH_FRAME_BYTES + `ETH_FCS_BYTES)

// 32-bit xorshift, shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Byte n of a field, counted from the least significant end
function automatic logic [7:0] byte_at(input logic [47:0] v, input int n);
    return v[8*n +: 8];
endfunction

// RFC 1071 sum over the header with its checksum bytes still zero
function automatic logic [15:0] ip_checksum(input logic [7:0] hdr [`ETH_IP_HDR_BYTES]);
    logic [31:0] sum;
    sum = '0;
    for (int i = 0; i < `ETH_IP_HDR_BYTES; i += 2) begin
        sum = sum + 32'({hdr[i], hdr[i + 1]});
    end
    // End-around carry until nothing is left above bit 15
    while (sum[31:16] != 16'h0) begin
        sum = 32'(sum[31:16]) + 32'(sum[15:0]);
    end
    return ~sum[15:0];
endfunction

// IEEE 802.3 CRC-32, bytewise, reflected, result complemented
function automatic logic [31:0] ethernet_crc(input logic [7:0] data [`ETH_LINE_BYTES],
                                             input int len);
    logic [31:0] crc;
    crc = '1;
    for (int i = 0; i < len; i++) begin
        crc = crc ^ 32'(data[i]);
        for (int k = 0; k < 8; k++) begin
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
        end
    end
    return ~crc;
endfunction

// Full expected line image, first byte at the MSB end
function automatic logic [8*`ETH_LINE_BYTES-1:0] expected_line(
    input logic [8*`ETH_DATA_BYTES-1:0] data,
    input logic [47:0]                  dmac,
    input logic [47:0]                  smac,
    input logic [31:0]                  sip,
    input logic [31:0]                  dip,
    input logic [15:0]                  sport,
    input logic [15:0]                  dport
);
    logic [7:0]                   b [`ETH_LINE_BYTES];
    logic [7:0]                   hdr [`ETH_IP_HDR_BYTES];
    logic [8*`ETH_LINE_BYTES-1:0] image;
    logic [15:0]                  csum;
    logic [31:0]                  fcs;
    int                           ip;
    int                           udp;
    int                           pay;
    ip  = `ETH_MAC_HDR_BYTES;
    udp = ip + `ETH_IP_HDR_BYTES;
    pay = udp + `ETH_UDP_HDR_BYTES;
    // Unset fields and padding stay zero
    b = '{default: 8'h00};
    // MAC header
    for (int i = 0; i < 6; i++) begin
        b[i]     = byte_at(dmac, 5 - i);
        b[6 + i] = byte_at(smac, 5 - i);
    end
    b[12] = byte_at(48'(`ETH_TYPE_IPV4), 1);
    b[13] = byte_at(48'(`ETH_TYPE_IPV4), 0);
    // Version 4, five-word header
    b[ip]     = 8'h45;
    b[ip + 2] = byte_at(48'(`ETH_IP_HDR_BYTES + `ETH_UDP_HDR_BYTES + `ETH_DATA_BYTES), 1);
    b[ip + 3] = byte_at(48'(`ETH_IP_HDR_BYTES + `ETH_UDP_HDR_BYTES + `ETH_DATA_BYTES), 0);
    b[ip + 8] = `ETH_IP_TTL;
    b[ip + 9] = `ETH_IP_PROTO_UDP;
    for (int i = 0; i < 4; i++) begin
        b[ip + 12 + i] = byte_at(48'(sip), 3 - i);
        b[ip + 16 + i] = byte_at(48'(dip), 3 - i);
    end
    // UDP header, checksum left at zero
    b[udp]     = sport[15:8];
    b[udp + 1] = sport[7:0];
    b[udp + 2] = dport[15:8];
    b[udp + 3] = dport[7:0];
    b[udp + 4] = byte_at(48'(`ETH_UDP_HDR_BYTES + `ETH_DATA_BYTES), 1);
    b[udp + 5] = byte_at(48'(`ETH_UDP_HDR_BYTES + `ETH_DATA_BYTES), 0);
    for (int i = 0; i < `ETH_DATA_BYTES; i++) begin
        b[pay + i] = data[8*(`ETH_DATA_BYTES - 1 - i) +: 8];
    end
    for (int i = 0; i < `ETH_IP_HDR_BYTES; i++) begin
        hdr[i] = b[ip + i];
    end
    csum = ip_checksum(hdr);
    b[ip + 10] = csum[15:8];
    b[ip + 11] = csum[7:0];
    // FCS goes out least significant byte first
    fcs = ethernet_crc(b, `ETH_FRAME_BYTES);
    for (int i = 0; i < `ETH_FCS_BYTES; i++) begin
        b[`ETH_FRAME_BYTES + i] = fcs[8*i +: 8];
    end
    for (int i = 0; i < `ETH_LINE_BYTES; i++) begin
        image[8*(`ETH_LINE_BYTES - 1 - i) +: 8] = b[i];
    end
    return image;
endfunction

`endif

// File: dv/eth_udp_tx_tb.sv
`include "eth_tx_macros.svh"

module eth_udp_tx_tb;

    timeunit 1ns;
    timeprecision 100ps;

    `include "eth_tx_ref.svh"

    localparam int          CLK_HALF          = 10;
    localparam int          DRIVE_DELAY       = 2;
    localparam int          RESET_CYCLES      = 5;
    localparam int          NUM_FRAMES        = 8;
    localparam int          TIMEOUT_CYCLES    = 400;
    localparam int          IDLE_CHECK_CYCLES = 60;
    // tx_en rises this many edges after the send edge
    localparam int          START_LATENCY     = 5;
    localparam logic [31:0] SEED              = 32'h5a0e_aaeb;
    localparam int          LINE_NIBBLES      = `ETH_PREAMBLE_NIBBLES + 2 * `ETH_LINE_BYTES;

    logic                         clk;
    logic                         reset;
    logic                         send;
    logic [8*`ETH_DATA_BYTES-1:0] payload;
    logic [47:0]                  src_mac;
    logic [47:0]                  dest_mac;
    logic [31:0]                  src_ip;
    logic [31:0]                  dest_ip;
    logic [15:0]                  src_port;
    logic [15:0]                  dest_port;
    logic                         ready;
    logic                         tx_en;
    logic [3:0]                   tx_d;

    logic [31:0] rng;
    // Rising edges since time zero
    int          cycle;
    int          errors;
    int          timeouts;
    int          frames_seen;
    int          rise_cycle;
    int          fall_cycle;
    logic        in_frame;
    // Nibbles of the frame now on the line
    logic [3:0]  cap [$];
    // One expected line image and send edge per accepted send
    logic [8*`ETH_LINE_BYTES-1:0] exp_q [$];
    int          edge_q [$];

    eth_udp_tx i_dut (
        .clk       (clk),
        .reset     (reset),
        .send      (send),
        .payload   (payload),
        .src_mac   (src_mac),
        .dest_mac  (dest_mac),
        .src_ip    (src_ip),
        .dest_ip   (dest_ip),
        .src_port  (src_port),
        .dest_port (dest_port),
        .ready     (ready),
        .tx_en     (tx_en),
        .tx_d      (tx_d)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Compare one captured frame with the oldest expected one
    task automatic check_frame();
        logic [8*`ETH_LINE_BYTES-1:0] exp_line;
        logic [7:0]                   got;
        logic [7:0]                   want;
        logic [3:0]                   pre;
        int                           edge_c;
        int                           pos;
        assert (exp_q.size() != 0) else begin
            errors++;
            $display("A frame appeared on the line without an accepted send");
        end
        if (exp_q.size() == 0) begin
            return;
        end
        exp_line = exp_q.pop_front();
        edge_c = edge_q.pop_front();
        assert (rise_cycle == edge_c + START_LATENCY) else begin
            errors++;
            $display("FAILED at %0d ns: tx_en rose %0d cycles after the send edge",
                     $time, rise_cycle - edge_c);
        end
        assert (cap.size() == LINE_NIBBLES) else begin
            errors++;
            $display("FAILED at %0d ns: tx_en high for %0d cycles, expected %0d",
                     $time, cap.size(), LINE_NIBBLES);
        end
        if (cap.size() != LINE_NIBBLES) begin
            return;
        end
        // Fifteen 0x5 then the SFD nibble
        for (int i = 0; i < `ETH_PREAMBLE_NIBBLES; i++) begin
            pre = (i == `ETH_PREAMBLE_NIBBLES - 1) ? 4'hD : 4'h5;
            assert (cap[i] == pre) else begin
                errors++;
                $display("FAILED at %0d ns: preamble nibble %0d is %h, expected %h",
                         $time, i, cap[i], pre);
            end
        end
        for (int b = 0; b < `ETH_LINE_BYTES; b++) begin
            pos = `ETH_PREAMBLE_NIBBLES + 2 * b;
            // Low nibble goes out first
            got  = {cap[pos + 1], cap[pos]};
            want = exp_line[8*(`ETH_LINE_BYTES - 1 - b) +: 8];
            assert (got == want) else begin
                errors++;
                $display("FAILED at %0d ns: %s byte %0d is %h, expected %h", $time,
                         (b < `ETH_FRAME_BYTES) ? "frame" : "FCS", b, got, want);
            end
        end
    endtask

    // Sampled on the falling edge where tx_en and tx_d are settled
    always @(negedge clk) begin
        if (tx_en) begin
            if (!in_frame) begin
                in_frame = 1'b1;
                rise_cycle = cycle;
                cap.delete();
                if (frames_seen > 0) begin
                    assert (rise_cycle - fall_cycle >= `ETH_GAP_NIBBLES) else begin
                        errors++;
                        $display("FAILED at %0d ns: only %0d idle cycles between frames",
                                 $time, rise_cycle - fall_cycle);
                    end
                end
            end
            cap.push_back(tx_d);
        end else if (in_frame) begin
            in_frame = 1'b0;
            fall_cycle = cycle;
            check_frame();
            frames_seen++;
        end
    end

    task automatic wait_tx_en();
        int n;
        n = 0;
        while (!tx_en && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            n++;
        end
        if (!tx_en) begin
            timeouts++;
            $display("Timeout: tx_en never went high after the send at %0d ns", $time);
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            n++;
        end
        if (!ready) begin
            timeouts++;
            $display("Timeout: ready did not return by %0d ns", $time);
        end
    endtask

    // Random frame with an optional second send edge while busy
    task automatic send_frame(input logic extra_edge);
        for (int w = 0; w < `ETH_DATA_BYTES / 4; w++) begin
            payload[32*w +: 32] = next_rand();
        end
        dest_mac[31:0]  = next_rand();
        dest_mac[47:32] = 16'(next_rand());
        src_mac[31:0]   = next_rand();
        src_mac[47:32]  = 16'(next_rand());
        src_ip          = next_rand();
        dest_ip         = next_rand();
        src_port        = 16'(next_rand());
        dest_port       = 16'(next_rand());
        exp_q.push_back(expected_line(payload, dest_mac, src_mac, src_ip, dest_ip,
                                      src_port, dest_port));
        // Sampled high at the coming edge
        edge_q.push_back(cycle + 1);
        send = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        send = 1'b0;
        wait_tx_en();
        if (timeouts != 0) begin
            return;
        end
        if (extra_edge) begin
            send = 1'b1;
            @(posedge clk);
            #DRIVE_DELAY;
            send = 1'b0;
        end
        wait_ready();
        if (timeouts != 0) begin
            return;
        end
        assert (cycle - fall_cycle >= `ETH_GAP_NIBBLES) else begin
            errors++;
            $display("FAILED at %0d ns: ready back %0d cycles after tx_en fell",
                     $time, cycle - fall_cycle);
        end
    endtask

    initial begin
        rng         = SEED;
        errors      = 0;
        timeouts    = 0;
        frames_seen = 0;
        rise_cycle  = 0;
        fall_cycle  = 0;
        in_frame    = 1'b0;
        reset       = 1'b1;
        send        = 1'b0;
        payload     = '0;
        src_mac     = '0;
        dest_mac    = '0;
        src_ip      = '0;
        dest_ip     = '0;
        src_port    = '0;
        dest_port   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        // Idle outputs before the first send
        assert (ready === 1'b1 && tx_en === 1'b0 && tx_d === 4'h0) else begin
            errors++;
            $display("FAILED at %0d ns: after reset ready=%b tx_en=%b tx_d=%h",
                     $time, ready, tx_en, tx_d);
        end
        for (int f = 0; f < NUM_FRAMES && timeouts == 0; f++) begin
            send_frame(f == NUM_FRAMES - 1);
        end
        if (timeouts == 0) begin
            // The edge dropped during the last frame starts nothing
            repeat (IDLE_CHECK_CYCLES) @(posedge clk);
            #DRIVE_DELAY;
            assert (frames_seen == NUM_FRAMES && !tx_en) else begin
                errors++;
                $display("FAILED at %0d ns: %0d frames on the line for %0d sends",
                         $time, frames_seen, NUM_FRAMES);
            end
        end
        $display("Value errors: %0d, timeouts: %0d, frames checked: %0d",
                 errors, timeouts, frames_seen);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+logic
+incdir+dv
logic/eth_tx_pkg.sv
logic/nibble_if.sv
logic/frame_builder.sv
logic/ip_checksum_stage.sv
logic/mii_serializer.sv
logic/fcs_inserter.sv
logic/eth_udp_tx.sv
dv/eth_udp_tx_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module eth_udp_tx_tb \
    -o eth_udp_tx_sim || { echo "Build failed"; exit 1; }
sim_out=$(./obj_dir/eth_udp_tx_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qx "No errors" && echo "PASS" || { echo "FAIL"; exit 1; }
